//--- include/book_params.svh
// Price book sizes and field widths, included by the book package and the testbench
`ifndef BOOK_PARAMS_SVH
`define BOOK_PARAMS_SVH

// Number of products with a book of their own
`define BOOK_PRODUCTS_N 8

// Product id, enough bits to index every product
`define BOOK_ID_W 3

// Price levels kept per book
`define BOOK_ENTRIES_N 4

// Price key of one level
`define BOOK_KEY_W 8

// Size carried by a single update
`define BOOK_SIZE_W 8

// Resting volume of one level
// Wider than the size so several adds accumulate before saturating
`define BOOK_VOLUME_W 12

`endif

//--- verilog/book_pkg.sv
// Shared types of the price book update pipeline, imported by every RTL module
`include "book_params.svh"

package book_pkg;

  // Basic fields
  typedef logic [`BOOK_ID_W-1:0] id_t;
  typedef logic [`BOOK_KEY_W-1:0] key_t;
  typedef logic [`BOOK_SIZE_W-1:0] size_t;
  typedef logic [`BOOK_VOLUME_W-1:0] volume_t;

  // Update command
  typedef enum logic {
    CMD_ADD = 1'b0,
    CMD_DEL = 1'b1
  } cmd_t;

  // One price level
  typedef struct packed {
    logic    valid;
    key_t    key;
    volume_t volume;
  } entry_t;

  // Whole book, index 0 is level 0
  // Ascending keys, valid entries packed at the low indices
  typedef entry_t [`BOOK_ENTRIES_N-1:0] state_t;

  // Update as accepted, S1 and S2 payload
  typedef struct packed {
    id_t   id;
    cmd_t  cmd;
    key_t  key;
    size_t size;
  } upd_t;

  // Execute stage payload, update plus the forwarded book
  typedef struct packed {
    upd_t   upd;
    state_t state;
  } exe_t;

  // Table write-back
  typedef struct packed {
    id_t    id;
    state_t state;
  } wrbk_t;

  // Level-0 change report
  typedef struct packed {
    id_t     id;
    key_t    key;
    volume_t volume;
  } notify_t;

endpackage

//--- verilog/stage_reg.sv
// Valid plus payload pipeline register, one instance per pipeline stage of the book update path
`timescale 1ns/1ps

module stage_reg #(
  parameter type T = logic
) (
  input  logic clk,
  input  logic rst,
  input  logic i_vld,
  input  T     i_data,
  output logic o_vld,
  output T     o_data
);

  // Only the valid bit is control state
  always_ff @(posedge clk) begin
    if (rst) begin
      o_vld <= 1'b0;
    end else begin
      o_vld <= i_vld;
    end
  end

  // Payload flops enabled by the incoming valid
  // Holds its value through idle cycles
  always_ff @(posedge clk) begin
    if (i_vld) begin
      o_data <= i_data;
    end
  end

  // Whatever reaches a valid stage must be fully known
  a_data_known: assert property (@(posedge clk) disable iff (rst)
    o_vld |-> !$isunknown(o_data));

endmodule

//--- verilog/state_table.sv
// Per-product book state memory of the update pipeline, registered read and edge write
`timescale 1ns/1ps
`include "book_params.svh"

module state_table (
  input  logic             clk,
  input  logic             rst,
  input  logic             i_ren,
  input  book_pkg::id_t    i_raddr,
  output book_pkg::state_t o_rdata,
  input  logic             i_wen,
  input  book_pkg::id_t    i_waddr,
  input  book_pkg::state_t i_wdata
);
  import book_pkg::*;

  // One book per product
  state_t                      mem [`BOOK_PRODUCTS_N];
  // Row has been written since reset
  logic [`BOOK_PRODUCTS_N-1:0] written_r;
  state_t                      rdata_r;

  // Written flags, cleared so every book starts empty
  always_ff @(posedge clk) begin
    if (rst) begin
      written_r <= '0;
    end else if (i_wen) begin
      written_r[i_waddr] <= 1'b1;
    end
  end

  // Row storage
  always_ff @(posedge clk) begin
    if (i_wen) begin
      mem[i_waddr] <= i_wdata;
    end
  end

  // Registered read, old data on a same-cycle write
  // Unwritten rows read as all-invalid
  always_ff @(posedge clk) begin
    if (i_ren) begin
      rdata_r <= written_r[i_raddr] ? mem[i_raddr] : '0;
    end
  end

  assign o_rdata = rdata_r;

  // S1 kills the read when write-back targets the same product
  a_no_rw_collision: assert property (@(posedge clk) disable iff (rst)
    !(i_ren && i_wen && (i_raddr == i_waddr)));

endmodule

//--- verilog/state_forward.sv
// Picks the freshest book state for the update leaving S2 of the book update pipeline
`timescale 1ns/1ps

module state_forward (
  input  book_pkg::id_t    i_s2_id,
  input  logic             i_s3_vld,
  input  book_pkg::id_t    i_s3_id,
  input  book_pkg::state_t i_s3_next,
  input  logic             i_wrbk_vld,
  input  book_pkg::wrbk_t  i_wrbk,
  input  logic             i_cap_vld,
  input  book_pkg::state_t i_cap_state,
  input  book_pkg::state_t i_table_rdata,
  output book_pkg::state_t o_state
);
  import book_pkg::*;

  logic   s3_hit;
  logic   wrbk_hit;
  logic   early_sel;
  state_t early_state;

  // Update one ahead, still executing
  assign s3_hit = i_s3_vld && (i_s3_id == i_s2_id);

  // Update two ahead, sitting in write-back
  assign wrbk_hit = i_wrbk_vld && (i_wrbk.id == i_s2_id);

  // Early sources, newest first
  // Captured write-back is three ahead and already folded into the table
  always_comb begin
    if (s3_hit) begin
      early_state = i_s3_next;
    end else if (wrbk_hit) begin
      early_state = i_wrbk.state;
    end else begin
      early_state = i_cap_state;
    end
  end

  assign early_sel = s3_hit | wrbk_hit | i_cap_vld;

  // Memory data arrives late in the cycle
  // so it goes through the last mux only
  assign o_state = early_sel ? early_state : i_table_rdata;

endmodule

//--- verilog/book_exe.sv
// Execute stage of the book update pipeline, applies add or delete and flags level-0 changes
`timescale 1ns/1ps
`include "book_params.svh"

module book_exe (
  input  book_pkg::upd_t    i_upd,
  input  book_pkg::state_t  i_state,
  output book_pkg::state_t  o_next,
  output logic              o_notify_vld,
  output book_pkg::key_t    o_notify_key,
  output book_pkg::volume_t o_notify_volume
);
  import book_pkg::*;

  localparam int N = `BOOK_ENTRIES_N;
  localparam int VOL_W = `BOOK_VOLUME_W;
  localparam int IDX_W = $clog2(N);
  localparam int POS_W = $clog2(N + 1);

  logic [N-1:0]     hit;
  logic             hit_any;
  logic [IDX_W-1:0] hit_idx;
  logic [POS_W-1:0] ins_pos;
  volume_t          size_ext;
  volume_t          hit_volume;
  logic [VOL_W:0]   add_sum;
  volume_t          add_volume;
  logic             del_all;
  entry_t           new_entry;
  logic             lvl0_changed;
  logic             next_sorted;

  // Key lookup and insert position
  // Position is the count of valid keys below the new key
  always_comb begin
    hit = '0;
    hit_idx = '0;
    ins_pos = '0;
    for (int i = 0; i < N; i++) begin
      if (i_state[i].valid && (i_state[i].key == i_upd.key)) begin
        hit[i] = 1'b1;
        hit_idx = IDX_W'(i);
      end
      if (i_state[i].valid && (i_state[i].key < i_upd.key)) begin
        ins_pos = ins_pos + 1'b1;
      end
    end
  end

  assign hit_any = |hit;

  // Volume arithmetic on the matched level
  assign size_ext = volume_t'(i_upd.size);
  assign hit_volume = i_state[hit_idx].volume;
  assign add_sum = {1'b0, hit_volume} + {1'b0, size_ext};
  // Saturate on carry out
  assign add_volume = add_sum[VOL_W] ? '1 : add_sum[VOL_W-1:0];
  assign del_all = (size_ext >= hit_volume);

  assign new_entry = '{valid: 1'b1, key: i_upd.key, volume: size_ext};

  // Next book
  always_comb begin
    o_next = i_state;
    if (i_upd.cmd == CMD_ADD) begin
      if (hit_any) begin
        o_next[hit_idx].volume = add_volume;
      end else if (ins_pos < N) begin
        // Shift up from the insert point, last level falls off
        for (int i = 1; i < N; i++) begin
          if (i > ins_pos) begin
            o_next[i] = i_state[i-1];
          end
        end
        o_next[ins_pos] = new_entry;
      end
      // Full book and key above the highest level, ignored
    end else if (hit_any) begin
      if (del_all) begin
        // Close the gap, tail becomes empty
        for (int i = 0; i < N - 1; i++) begin
          if (i >= hit_idx) begin
            o_next[i] = i_state[i+1];
          end
        end
        o_next[N-1] = '0;
      end else begin
        o_next[hit_idx].volume = hit_volume - size_ext;
      end
    end
  end

  // Level 0 compare, key and volume only matter while valid
  assign lvl0_changed = (o_next[0].valid != i_state[0].valid) ||
                        (o_next[0].valid &&
                         ((o_next[0].key != i_state[0].key) ||
                          (o_next[0].volume != i_state[0].volume)));

  assign o_notify_vld = lvl0_changed;
  // Empty book reports zero and zero
  assign o_notify_key = o_next[0].valid ? o_next[0].key : '0;
  assign o_notify_volume = o_next[0].valid ? o_next[0].volume : '0;

  // Valid entries first, strictly ascending keys
  always_comb begin
    next_sorted = 1'b1;
    for (int i = 0; i < N - 1; i++) begin
      if (o_next[i+1].valid &&
          !(o_next[i].valid && (o_next[i].key < o_next[i+1].key))) begin
        next_sorted = 1'b0;
      end
    end
  end

  // Idle S3 payload is unknown until the first update
  always_comb begin
    if (!$isunknown(i_upd) && !$isunknown(i_state)) begin
      a_next_sorted: assert final (next_sorted);
    end
  end

endmodule

//--- verilog/book_update_pipe.sv
// Top level of the price book update pipeline, one update per cycle in, level-0 notifies out
`timescale 1ns/1ps

module book_update_pipe (
  input  logic              clk,
  input  logic              rst,
  input  logic              i_upd_vld,
  input  book_pkg::upd_t    i_upd,
  output logic              o_notify_vld,
  output book_pkg::notify_t o_notify
);
  import book_pkg::*;

  // S1
  logic    s1_vld;
  upd_t    s1_upd;
  logic    s1_wrbk_hit;
  logic    s1_ren;
  // S2
  logic    s2_vld;
  upd_t    s2_upd;
  logic    cap_vld_r;
  state_t  cap_state_r;
  state_t  table_rdata;
  state_t  s2_state;
  exe_t    s3_in;
  // S3
  logic    s3_vld;
  exe_t    s3_data;
  state_t  s3_next;
  logic    exe_notify_vld;
  key_t    exe_notify_key;
  volume_t exe_notify_volume;
  // Write-back and notify
  wrbk_t   wrbk_in;
  logic    wrbk_vld;
  wrbk_t   wrbk;
  logic    notify_in_vld;
  notify_t notify_in;

  // S1 holds the accepted update
  stage_reg #(.T(upd_t)) u_s1 (
    .clk    (clk),
    .rst    (rst),
    .i_vld  (i_upd_vld),
    .i_data (i_upd),
    .o_vld  (s1_vld),
    .o_data (s1_upd)
  );

  // Write-back to the same product this cycle
  // Table would return the old row so take the write-back data instead
  assign s1_wrbk_hit = wrbk_vld && (wrbk.id == s1_upd.id);
  assign s1_ren = s1_vld && !s1_wrbk_hit;

  state_table u_state_table (
    .clk     (clk),
    .rst     (rst),
    .i_ren   (s1_ren),
    .i_raddr (s1_upd.id),
    .o_rdata (table_rdata),
    .i_wen   (wrbk_vld),
    .i_waddr (wrbk.id),
    .i_wdata (wrbk.state)
  );

  // S2 where the book state arrives
  stage_reg #(.T(upd_t)) u_s2 (
    .clk    (clk),
    .rst    (rst),
    .i_vld  (s1_vld),
    .i_data (s1_upd),
    .o_vld  (s2_vld),
    .o_data (s2_upd)
  );

  // Captured write-back moves with S2
  always_ff @(posedge clk) begin
    if (rst) begin
      cap_vld_r <= 1'b0;
    end else if (s1_vld) begin
      cap_vld_r <= s1_wrbk_hit;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_vld) begin
      cap_state_r <= wrbk.state;
    end
  end

  state_forward u_state_forward (
    .i_s2_id       (s2_upd.id),
    .i_s3_vld      (s3_vld),
    .i_s3_id       (s3_data.upd.id),
    .i_s3_next     (s3_next),
    .i_wrbk_vld    (wrbk_vld),
    .i_wrbk        (wrbk),
    .i_cap_vld     (cap_vld_r),
    .i_cap_state   (cap_state_r),
    .i_table_rdata (table_rdata),
    .o_state       (s2_state)
  );

  assign s3_in = '{upd: s2_upd, state: s2_state};

  // S3 executes
  stage_reg #(.T(exe_t)) u_s3 (
    .clk    (clk),
    .rst    (rst),
    .i_vld  (s2_vld),
    .i_data (s3_in),
    .o_vld  (s3_vld),
    .o_data (s3_data)
  );

  book_exe u_book_exe (
    .i_upd           (s3_data.upd),
    .i_state         (s3_data.state),
    .o_next          (s3_next),
    .o_notify_vld    (exe_notify_vld),
    .o_notify_key    (exe_notify_key),
    .o_notify_volume (exe_notify_volume)
  );

  // Every executed update writes back even with no change
  assign wrbk_in = '{id: s3_data.upd.id, state: s3_next};

  stage_reg #(.T(wrbk_t)) u_wrbk (
    .clk    (clk),
    .rst    (rst),
    .i_vld  (s3_vld),
    .i_data (wrbk_in),
    .o_vld  (wrbk_vld),
    .o_data (wrbk)
  );

  // Notify only on a level-0 change
  assign notify_in_vld = s3_vld && exe_notify_vld;
  assign notify_in = '{id: s3_data.upd.id, key: exe_notify_key, volume: exe_notify_volume};

  stage_reg #(.T(notify_t)) u_notify (
    .clk    (clk),
    .rst    (rst),
    .i_vld  (notify_in_vld),
    .i_data (notify_in),
    .o_vld  (o_notify_vld),
    .o_data (o_notify)
  );

endmodule

//--- testbench/tb_clk_gen.sv
// Testbench clock and reset source for the book update pipeline, 4 ns clock and 3-cycle reset
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter realtime PERIOD = 4.0ns,
  parameter int      RST_CYCLES = 3
) (
  output logic clk,
  output logic rst
);

  // Free-running clock, starts low
  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2.0) clk = ~clk;
  end

  // Reset high across the first rising edges
  initial begin
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

//--- testbench/tb_book_update.sv
// Testbench for the book update pipeline, directed and random updates checked against a book model
`timescale 1ns/1ps
`include "book_params.svh"

module tb_book_update;
  import book_pkg::*;

  localparam int ENTRIES = `BOOK_ENTRIES_N;
  localparam int VOL_MAX = (1 << `BOOK_VOLUME_W) - 1;
  localparam int DIRECTED_UPDATES = 48;
  localparam int RANDOM_UPDATES = 600;
  // One cycle per update plus room for reset, gaps and drain
  localparam int CYCLE_LIMIT = DIRECTED_UPDATES + RANDOM_UPDATES + 100;

  logic    clk;
  logic    rst;
  logic    upd_vld;
  upd_t    upd;
  logic    notify_vld;
  notify_t notify;

  // Reference books, one sorted list per product
  int          book_cnt [`BOOK_PRODUCTS_N];
  int          book_key [`BOOK_PRODUCTS_N][ENTRIES];
  int          book_vol [`BOOK_PRODUCTS_N][ENTRIES];
  notify_t     expect_q [$];
  logic [31:0] rng_state;
  int          errors;
  int          compared;
  int          sent;
  int          cycles;

  tb_clk_gen u_tb_clk_gen (
    .clk (clk),
    .rst (rst)
  );

  book_update_pipe u_book_update_pipe (
    .clk          (clk),
    .rst          (rst),
    .i_upd_vld    (upd_vld),
    .i_upd        (upd),
    .o_notify_vld (notify_vld),
    .o_notify     (notify)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Applies one update to the model book
  // Returns 1 when level 0 changed, n then holds the expected notify
  function automatic bit model_update(input upd_t u, output notify_t n);
    int cnt;
    int hit;
    int pos;
    bit top_was;
    int top_key;
    int top_vol;
    bit top_now;
    cnt = book_cnt[u.id];
    top_was = (cnt > 0);
    top_key = book_key[u.id][0];
    top_vol = book_vol[u.id][0];
    hit = -1;
    pos = 0;
    for (int i = 0; i < cnt; i++) begin
      if (book_key[u.id][i] == int'(u.key)) begin
        hit = i;
      end
      if (book_key[u.id][i] < int'(u.key)) begin
        pos++;
      end
    end
    if (u.cmd == CMD_ADD) begin
      if (hit >= 0) begin
        book_vol[u.id][hit] = book_vol[u.id][hit] + int'(u.size);
        if (book_vol[u.id][hit] > VOL_MAX) begin
          book_vol[u.id][hit] = VOL_MAX;
        end
      end else if (cnt < ENTRIES || int'(u.key) < book_key[u.id][ENTRIES-1]) begin
        // Full book loses its highest level
        if (cnt == ENTRIES) begin
          cnt = ENTRIES - 1;
        end
        for (int i = cnt; i > pos; i--) begin
          book_key[u.id][i] = book_key[u.id][i-1];
          book_vol[u.id][i] = book_vol[u.id][i-1];
        end
        book_key[u.id][pos] = int'(u.key);
        book_vol[u.id][pos] = int'(u.size);
        cnt++;
      end
    end else if (hit >= 0) begin
      if (int'(u.size) >= book_vol[u.id][hit]) begin
        for (int i = hit; i < cnt - 1; i++) begin
          book_key[u.id][i] = book_key[u.id][i+1];
          book_vol[u.id][i] = book_vol[u.id][i+1];
        end
        cnt--;
      end else begin
        book_vol[u.id][hit] = book_vol[u.id][hit] - int'(u.size);
      end
    end
    book_cnt[u.id] = cnt;
    top_now = (cnt > 0);
    n.id = u.id;
    // Empty book reports zero key and volume
    n.key = top_now ? key_t'(book_key[u.id][0]) : '0;
    n.volume = top_now ? volume_t'(book_vol[u.id][0]) : '0;
    return (top_now != top_was) ||
           (top_now && ((int'(n.key) != top_key) || (int'(n.volume) != top_vol)));
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      errors++;
      $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, expected);
    end
  endtask

  // One-cycle strobe, falling edge drive
  task automatic send_update(input int id, input cmd_t cmd, input int key, input int size);
    upd_t    u;
    notify_t n;
    u.id = id_t'(id);
    u.cmd = cmd;
    u.key = key_t'(key);
    u.size = size_t'(size);
    @(negedge clk);
    upd_vld = 1'b1;
    upd = u;
    if (model_update(u, n)) begin
      expect_q.push_back(n);
    end
    sent++;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(negedge clk);
      upd_vld = 1'b0;
    end
  endtask

  // Notifies leave in update order, one expected entry per pulse
  always @(negedge clk) begin : compare_notify
    notify_t exp_n;
    if (!rst && notify_vld) begin
      if (expect_q.size() == 0) begin
        errors++;
        $display("Notify for product %0d at %0t came with no level-0 change pending",
                 notify.id, $time);
      end else begin
        exp_n = expect_q.pop_front();
        check_value("notify id", 32'(notify.id), 32'(exp_n.id));
        check_value("notify key", 32'(notify.key), 32'(exp_n.key));
        check_value("notify volume", 32'(notify.volume), 32'(exp_n.volume));
        compared++;
      end
    end
  end

  // Run limit
  initial begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("Run stopped after %0d cycles, stimulus or drain did not finish", cycles);
    $display("Compared %0d notifies, %0d errors", compared, errors);
    $display("Test failed");
    $finish;
  end

  initial begin
    upd_vld = 1'b0;
    upd = '0;
    errors = 0;
    compared = 0;
    sent = 0;
    rng_state = 32'h3248_6c07;
    for (int p = 0; p < `BOOK_PRODUCTS_N; p++) begin
      book_cnt[p] = 0;
      for (int e = 0; e < ENTRIES; e++) begin
        book_key[p][e] = 0;
        book_vol[p][e] = 0;
      end
    end
    wait (!rst);
    // Quiet after reset, any notify here is unexpected
    idle_cycles(5);

    // First add to an empty book
    send_update(0, CMD_ADD, 50, 10);
    send_update(5, CMD_ADD, 200, 3);

    // Higher keys stay behind the top, lower key takes it
    send_update(1, CMD_ADD, 100, 5);
    idle_cycles(2);
    send_update(1, CMD_ADD, 120, 6);
    send_update(1, CMD_ADD, 110, 8);
    send_update(1, CMD_ADD, 90, 7);
    // Top volume grows until it saturates, last add changes nothing
    repeat (18) begin
      send_update(1, CMD_ADD, 90, 255);
    end

    // Full book: 90 100 110 120
    send_update(1, CMD_ADD, 130, 9);
    send_update(1, CMD_ADD, 80, 4);
    send_update(1, CMD_ADD, 105, 2);

    // Partial then full delete of the top, absent key ignored
    send_update(1, CMD_DEL, 80, 1);
    send_update(1, CMD_DEL, 80, 3);
    send_update(1, CMD_DEL, 77, 5);
    send_update(2, CMD_ADD, 40, 9);
    idle_cycles(3);
    send_update(2, CMD_DEL, 40, 20);

    // Same product with gaps of 0 to 3 cycles
    // covers execute, write-back, capture and table paths
    for (int gap = 0; gap < 4; gap++) begin
      send_update(3, CMD_ADD, 70 - gap * 5, 1 + gap);
      idle_cycles(gap);
      send_update(3, CMD_ADD, 70 - gap * 5, 3);
      idle_cycles(gap);
      send_update(3, CMD_DEL, 70 - gap * 5, 2);
      send_update(4, CMD_ADD, 30 + gap, 2);
    end

    // Random stream over products 6 and 7, narrow key range for many hits
    for (int k = 0; k < RANDOM_UPDATES; k++) begin
      rng_state = xorshift32(rng_state);
      send_update(6 + int'(rng_state[0]),
                  (rng_state[6:4] < 3'd3) ? CMD_DEL : CMD_ADD,
                  100 + int'(rng_state[10:8]),
                  int'(rng_state[23:16]));
    end

    // Drain the pipeline
    idle_cycles(10);
    @(posedge clk);
    if (expect_q.size() != 0) begin
      errors++;
      $display("%0d expected notifies never arrived", expect_q.size());
    end
    $display("Sent %0d updates, compared %0d notifies, %0d errors", sent, compared, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- verilog.f
+incdir+include
verilog/book_pkg.sv
verilog/stage_reg.sv
verilog/state_table.sv
verilog/state_forward.sv
verilog/book_exe.sv
verilog/book_update_pipe.sv
testbench/tb_clk_gen.sv
testbench/tb_book_update.sv

//--- Bender.yml
package:
  name: book_update_pipe

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/book_pkg.sv
      - verilog/stage_reg.sv
      - verilog/state_table.sv
      - verilog/state_forward.sv
      - verilog/book_exe.sv
      - verilog/book_update_pipe.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/tb_clk_gen.sv
      - testbench/tb_book_update.sv
